// File: fp_coprocessor.f
verilog/fp_pkg.sv
verilog/apb_slave.sv
verilog/scheduler.sv
verilog/fp_add_unit.sv
verilog/fp_mul_unit.sv
verilog/fp_sign_unit.sv
verilog/reg_file.sv
verilog/fp_coprocessor.sv
verif/tb_fp_coprocessor.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_fp_coprocessor \
  -f fp_coprocessor.f -o tb_fp_coprocessor

./obj_dir/tb_fp_coprocessor | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: verif/fp_test_input.txt
# op f1 f2 f3, hex: W reg value 0 | I instr 0 0 | E instr queue_count 0
# R reg expected_value busy_err (busy_err 1 reads at once and expects pslverr)
W 1 3fc00000 0
W 2 40200000 0
W 6 3f800000 0
W 7 3f800001 0
W 8 34400000 0
W 9 0d800000 0
W a 8d800000 0
W b 71800000 0
R 1 3fc00000 0
R a 8d800000 0
R b 71800000 0
I 3312 0 0
R 3 0 1
I 1431 0 0
R 4 0 1
I 4540 0 0
R 3 40700000 0
R 4 40a80000 0
R 5 c0a80000 0
I 1012 0 0
I 2f76 0 0
I 1e68 0 0
I 3d9a 0 0
I 3cbb 0 0
I 4310 0 0
I 54a0 0 0
I 6520 0 0
R 0 40800000 0
R f 34000000 0
R e 3f800001 0
R d 80000000 0
R c 7f800000 0
R 3 bfc00000 0
R 4 0d800000 0
R 5 40200000 0
E 7e12 0 0
E fe12 0 0
R e 3f800001 0

// File: verif/tb_fp_coprocessor.sv
// ----------------------------------------------------------------------
// fp coprocessor testbench
// replays APB operations from the data file and checks register values,
// error responses and queue occupancy against the expected columns
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_fp_coprocessor
  import fp_pkg::*;
();

  localparam int    CYCLES_PER_LINE = 200;
  localparam string DATA_FILE       = "verif/fp_test_input.txt";

  logic        clk, reset;
  logic [7:0]  paddr;
  logic        psel, penable, pwrite;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;

  // operations from the data file, one entry per line
  logic [7:0]  op_list [$];
  logic [31:0] f1_list [$];
  logic [31:0] f2_list [$];
  logic [31:0] f3_list [$];
  int          n_ops;
  logic        loaded;

  int data_errs, flag_errs, count_errs, ready_errs, other_errs;

  fp_coprocessor #(.FIFO_DEPTH(8)) dut_i (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic logic [7:0] reg_byte_addr(input reg_addr_t r);
    return ADDR_REG_BASE + {2'b00, r, 2'b00};
  endfunction

  task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      data_errs++;
      $display("ERR %0t: %s read %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      flag_errs++;
      $display("ERR %0t: %s gave pslverr %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input logic [4:0] got, input logic [4:0] exp, input string what);
    if (got !== exp) begin
      count_errs++;
      $display("ERR %0t: %s queue count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      ready_errs++;
      $display("ERR %0t: %s gave pready %b, expected %b", $time, what, got, exp);
    end
  endtask

  // setup on one falling edge, access on the next
  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;  // mid access cycle, outputs settled
    rdata = prdata;
    err   = pslverr;
    check_ready(pready, 1'b1, $sformatf("access at %02h", addr));  // zero wait states
    @(posedge clk);
  endtask

  task automatic wait_reg_idle(input reg_addr_t r);
    logic [31:0] st;
    logic        err;
    apb_xfer(ADDR_STATUS, 1'b0, 32'd0, st, err);
    while (st[r]) apb_xfer(ADDR_STATUS, 1'b0, 32'd0, st, err);
  endtask

  task automatic check_reset_state();
    logic [31:0] rd;
    logic        err;
    apb_xfer(ADDR_STATUS, 1'b0, 32'd0, rd, err);
    check_err(err, 1'b0, "status read after reset");
    check_data(rd, 32'd0, "status after reset");
    for (int r = 0; r < NUM_REGS; r++) begin
      apb_xfer(reg_byte_addr(reg_addr_t'(r)), 1'b0, 32'd0, rd, err);
      check_err(err, 1'b0, $sformatf("r%0d read after reset", r));
      check_data(rd, 32'd0, $sformatf("r%0d after reset", r));
    end
  endtask

  task automatic load_ops(input int fd);
    int          n, ch;
    logic [7:0]  op;
    logic [31:0] a, b, c;
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) break;
      if (op == "#") begin
        ch = $fgetc(fd);  // comment, skip to end of line
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else begin
        a = 0;
        b = 0;
        c = 0;
        n = $fscanf(fd, "%h %h %h", a, b, c);
        if (n != 3) begin
          other_errs++;
          $display("data file line for operation %c does not hold three fields", op);
        end
        op_list.push_back(op);
        f1_list.push_back(a);
        f2_list.push_back(b);
        f3_list.push_back(c);
      end
    end
  endtask

  task automatic run_op(input logic [7:0] op, input logic [31:0] f1, input logic [31:0] f2,
                        input logic [31:0] f3);
    logic [31:0] rd;
    logic        err;
    reg_addr_t   r;
    r = f1[3:0];
    case (op)
      "W": begin
        apb_xfer(reg_byte_addr(r), 1'b1, f2, rd, err);
        check_err(err, 1'b0, $sformatf("write r%0d", r));
      end
      "I": begin
        apb_xfer(ADDR_INSTR, 1'b1, f1, rd, err);
        check_err(err, 1'b0, $sformatf("instruction %04h", f1[15:0]));
      end
      "E": begin
        apb_xfer(ADDR_INSTR, 1'b1, f1, rd, err);
        check_err(err, 1'b1, $sformatf("rejected instruction %04h", f1[15:0]));
        apb_xfer(ADDR_STATUS, 1'b0, 32'd0, rd, err);
        check_count(rd[20:16], f2[4:0], $sformatf("after instruction %04h", f1[15:0]));
      end
      "R": begin
        if (f3[0]) begin  // read while the result is still pending
          apb_xfer(reg_byte_addr(r), 1'b0, 32'd0, rd, err);
          check_err(err, 1'b1, $sformatf("read of busy r%0d", r));
        end else begin
          wait_reg_idle(r);
          apb_xfer(reg_byte_addr(r), 1'b0, 32'd0, rd, err);
          check_err(err, 1'b0, $sformatf("read r%0d", r));
          check_data(rd, f2, $sformatf("r%0d", r));
        end
      end
      default: begin
        other_errs++;
        $display("data file holds an unknown operation %c", op);
      end
    endcase
  endtask

  initial begin
    int fd;
    int total;
    clk     = 1'b0;
    reset   = 1'b1;
    paddr   = 8'd0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = 32'd0;
    loaded  = 1'b0;
    n_ops   = 0;
    data_errs  = 0;
    flag_errs  = 0;
    count_errs = 0;
    ready_errs = 0;
    other_errs = 0;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open the data file %s", DATA_FILE);
      $display(">>> FAIL");
      $finish;
    end else begin
      load_ops(fd);
      $fclose(fd);
      n_ops  = op_list.size();
      loaded = 1'b1;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      check_reset_state();
      for (int i = 0; i < n_ops; i++) run_op(op_list[i], f1_list[i], f2_list[i], f3_list[i]);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      total = data_errs + flag_errs + count_errs + ready_errs + other_errs;
      $display("errors: data %0d, error flag %0d, queue count %0d, ready %0d, other %0d",
               data_errs, flag_errs, count_errs, ready_errs, other_errs);
      if (total == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

  // budget scales with the number of operations in the file
  initial begin
    int limit;
    wait (loaded);
    limit = (n_ops + 1) * CYCLES_PER_LINE;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: verilog/apb_slave.sv
// ----------------------------------------------------------------------
// APB slave, zero wait states
// decodes the address map into instruction, register write and register
// read strobes, and flags full queue, bad opcodes and busy registers
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module apb_slave
  import fp_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic [7:0]         paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               instr_valid,
  output logic [INSTR_W-1:0] instr,
  input  logic               queue_full,
  output logic               host_wr,
  output reg_addr_t          host_addr,
  output logic [31:0]        host_data,
  output reg_addr_t          host_rd_addr,
  input  logic [31:0]        host_rd_data,
  input  logic [15:0]        busy_mask,
  input  logic [4:0]         queue_count
);

  logic      setup_seen;
  logic      access;
  logic      is_instr, is_status, is_reg;
  logic      op_ok;
  logic      reg_busy;
  reg_addr_t reg_idx;
  logic      err;

  // one decode per transfer, only after a proper setup phase
  always_ff @(posedge clk) begin
    if (reset) begin
      setup_seen <= 1'b0;
    end else begin
      setup_seen <= psel & ~penable;
    end
  end

  assign access    = psel & penable & setup_seen;
  assign is_instr  = (paddr == ADDR_INSTR);
  assign is_status = (paddr == ADDR_STATUS);
  assign is_reg    = (paddr[7:6] == ADDR_REG_BASE[7:6]) && (paddr[1:0] == 2'b00);
  assign reg_idx   = paddr[5:2];
  assign reg_busy  = busy_mask[reg_idx];

  always_comb begin
    case (opcode_t'(pwdata[INSTR_W-1 -: 4]))
      op_nop, op_add, op_sub, op_mul, op_neg, op_abs, op_mov: op_ok = 1'b1;
      default: op_ok = 1'b0;
    endcase
  end

  always_comb begin
    if (is_instr) begin
      err = ~pwrite | queue_full | ~op_ok;  // port is write only
    end else if (is_reg) begin
      err = reg_busy;  // pending writeback, both directions
    end else if (is_status) begin
      err = pwrite;
    end else begin
      err = 1'b1;  // unmapped
    end
  end

  assign pready  = 1'b1;
  assign pslverr = access & err;

  assign instr_valid  = access & pwrite & is_instr & ~err;
  assign instr        = pwdata[INSTR_W-1:0];
  assign host_wr      = access & pwrite & is_reg & ~err;
  assign host_addr    = reg_idx;
  assign host_data    = pwdata;
  assign host_rd_addr = reg_idx;

  // status word is count in [20:16] and busy mask in [15:0]
  always_comb begin
    if (is_reg) begin
      prdata = host_rd_data;
    end else if (is_status) begin
      prdata = {11'b0, queue_count, busy_mask};
    end else begin
      prdata = 32'b0;
    end
  end

endmodule

// File: verilog/fp_add_unit.sv
// ----------------------------------------------------------------------
// single precision add/subtract, two stages
// stage one orders and aligns, stage two adds, normalizes and truncates
// with flush to zero and overflow to infinity
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fp_add_unit
  import fp_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        add_issue,
  input  opcode_t     issue_op,
  input  reg_addr_t   issue_dest,
  input  logic [31:0] opa,
  input  logic [31:0] opb,
  output logic        add_done,
  output reg_addr_t   add_dest,
  output logic [31:0] add_result
);

  logic        sb, a_big;
  logic [23:0] ma, mb;
  logic [7:0]  big_exp, diff;
  logic        s1_valid, s1_sign, s1_sub;
  reg_addr_t   s1_dest;
  logic [7:0]  s1_exp;
  logic [23:0] s1_big, s1_small;
  logic [24:0] sum;
  logic [4:0]  lz;
  logic [23:0] norm;
  logic signed [9:0] exp_n;
  logic [31:0] result;

  function automatic logic [4:0] lzc24(input logic [23:0] v);
    logic [4:0] n;
    logic       found;
    n = 5'd24;
    found = 1'b0;
    for (int i = 23; i >= 0; i--) begin
      if (!found && v[i]) begin
        n = 5'(23 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  assign sb    = opb[31] ^ (issue_op == op_sub);
  assign ma    = (opa[30:23] != 8'd0) ? {1'b1, opa[22:0]} : 24'd0;  // denormal in flushes
  assign mb    = (opb[30:23] != 8'd0) ? {1'b1, opb[22:0]} : 24'd0;
  assign a_big = (opa[30:0] >= opb[30:0]);
  assign big_exp = a_big ? opa[30:23] : opb[30:23];
  assign diff    = a_big ? opa[30:23] - opb[30:23] : opb[30:23] - opa[30:23];

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      add_done <= 1'b0;
    end else begin
      s1_valid <= add_issue;
      add_done <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (add_issue) begin
      s1_dest  <= issue_dest;
      s1_sign  <= a_big ? opa[31] : sb;
      s1_sub   <= opa[31] ^ sb;
      s1_exp   <= big_exp;
      s1_big   <= a_big ? ma : mb;
      s1_small <= (a_big ? mb : ma) >> diff;  // no guard bits
    end
  end

  always_comb begin
    sum = s1_sub ? {1'b0, s1_big} - {1'b0, s1_small} : {1'b0, s1_big} + {1'b0, s1_small};
    lz  = lzc24(sum[23:0]);
    if (sum[24]) begin
      norm  = sum[24:1];
      exp_n = $signed({2'b0, s1_exp}) + 10'sd1;
    end else begin
      norm  = sum[23:0] << lz;
      exp_n = $signed({2'b0, s1_exp}) - $signed({5'b0, lz});
    end
    if (sum == 25'd0) begin
      result = {s1_sign & ~s1_sub, 31'b0};  // exact cancel gives +0
    end else if (exp_n >= 10'sd255) begin
      result = {s1_sign, 8'hff, 23'b0};
    end else if (exp_n <= 10'sd0) begin
      result = {s1_sign, 31'b0};
    end else begin
      result = {s1_sign, exp_n[7:0], norm[22:0]};
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      add_dest   <= s1_dest;
      add_result <= result;
    end
  end

endmodule

// File: verilog/fp_coprocessor.sv
// ----------------------------------------------------------------------
// floating point coprocessor top
// APB slave, scheduler, three execution units and the register file
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fp_coprocessor
  import fp_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic        clk,
  input  logic        reset,
  input  logic [7:0]  paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic                instr_valid, queue_full;
  logic [INSTR_W-1:0]  instr;
  logic [4:0]          queue_count;
  logic [NUM_REGS-1:0] busy_mask;
  logic                host_wr;
  reg_addr_t           host_addr, host_rd_addr;
  logic [31:0]         host_data, host_rd_data;

  // issue side
  logic                add_issue, mul_issue, sign_issue;
  opcode_t             issue_op;
  reg_addr_t           issue_dest, src1, src2;
  logic [31:0]         opa, opb;

  // writeback side
  logic                add_done, mul_done, sign_done;
  reg_addr_t           add_dest, mul_dest, sign_dest;
  logic [31:0]         add_result, mul_result, sign_result;

  apb_slave apb_slave_i (
    .clk(clk), .reset(reset),
    .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .instr_valid(instr_valid), .instr(instr), .queue_full(queue_full),
    .host_wr(host_wr), .host_addr(host_addr), .host_data(host_data),
    .host_rd_addr(host_rd_addr), .host_rd_data(host_rd_data),
    .busy_mask(busy_mask), .queue_count(queue_count)
  );

  scheduler #(.FIFO_DEPTH(FIFO_DEPTH)) scheduler_i (
    .clk(clk), .reset(reset),
    .instr_valid(instr_valid), .instr(instr),
    .queue_full(queue_full), .queue_count(queue_count), .busy_mask(busy_mask),
    .add_issue(add_issue), .mul_issue(mul_issue), .sign_issue(sign_issue),
    .issue_op(issue_op), .issue_dest(issue_dest), .src1(src1), .src2(src2),
    .add_done(add_done), .mul_done(mul_done), .sign_done(sign_done),
    .add_dest(add_dest), .mul_dest(mul_dest), .sign_dest(sign_dest)
  );

  fp_add_unit fp_add_unit_i (
    .clk(clk), .reset(reset),
    .add_issue(add_issue), .issue_op(issue_op), .issue_dest(issue_dest),
    .opa(opa), .opb(opb),
    .add_done(add_done), .add_dest(add_dest), .add_result(add_result)
  );

  fp_mul_unit fp_mul_unit_i (
    .clk(clk), .reset(reset),
    .mul_issue(mul_issue), .issue_dest(issue_dest),
    .opa(opa), .opb(opb),
    .mul_done(mul_done), .mul_dest(mul_dest), .mul_result(mul_result)
  );

  fp_sign_unit fp_sign_unit_i (
    .clk(clk), .reset(reset),
    .sign_issue(sign_issue), .issue_op(issue_op), .issue_dest(issue_dest),
    .opa(opa),
    .sign_done(sign_done), .sign_dest(sign_dest), .sign_result(sign_result)
  );

  reg_file reg_file_i (
    .clk(clk), .reset(reset),
    .add_done(add_done), .mul_done(mul_done), .sign_done(sign_done),
    .add_dest(add_dest), .mul_dest(mul_dest), .sign_dest(sign_dest),
    .add_result(add_result), .mul_result(mul_result), .sign_result(sign_result),
    .host_wr(host_wr), .host_addr(host_addr), .host_data(host_data),
    .src1(src1), .src2(src2), .opa(opa), .opb(opb),
    .host_rd_addr(host_rd_addr), .host_rd_data(host_rd_data)
  );

endmodule

// File: verilog/fp_mul_unit.sv
// ----------------------------------------------------------------------
// single precision multiply, two stages
// mantissa product and exponent sum, then one bit normalize and truncate
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fp_mul_unit
  import fp_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        mul_issue,
  input  reg_addr_t   issue_dest,
  input  logic [31:0] opa,
  input  logic [31:0] opb,
  output logic        mul_done,
  output reg_addr_t   mul_dest,
  output logic [31:0] mul_result
);

  logic              s1_valid, s1_sign, s1_zero;
  reg_addr_t         s1_dest;
  logic [47:0]       s1_prod;
  logic signed [9:0] s1_exp;
  logic signed [9:0] exp_n;
  logic [22:0]       frac;
  logic [31:0]       result;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      mul_done <= 1'b0;
    end else begin
      s1_valid <= mul_issue;
      mul_done <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_issue) begin
      s1_dest <= issue_dest;
      s1_sign <= opa[31] ^ opb[31];
      s1_zero <= (opa[30:23] == 8'd0) || (opb[30:23] == 8'd0);  // zero or denormal in
      s1_prod <= {1'b1, opa[22:0]} * {1'b1, opb[22:0]};
      s1_exp  <= $signed({2'b0, opa[30:23]}) + $signed({2'b0, opb[30:23]}) - 10'sd127;
    end
  end

  // product lies in [1,4), so at most one bit of shift
  assign exp_n = s1_prod[47] ? s1_exp + 10'sd1 : s1_exp;
  assign frac  = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];

  always_comb begin
    if (s1_zero || exp_n <= 10'sd0) begin
      result = {s1_sign, 31'b0};
    end else if (exp_n >= 10'sd255) begin
      result = {s1_sign, 8'hff, 23'b0};
    end else begin
      result = {s1_sign, exp_n[7:0], frac};
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      mul_dest   <= s1_dest;
      mul_result <= result;
    end
  end

endmodule

// File: verilog/fp_pkg.sv
// ----------------------------------------------------------------------
// fp coprocessor shared definitions
// opcodes, instruction fields, register index type and APB address map
// ----------------------------------------------------------------------

package fp_pkg;

  // instruction word layout is opcode[15:12] dest[11:8] src1[7:4] src2[3:0]
  localparam int INSTR_W = 16;
  localparam int NUM_REGS = 16;

  typedef logic [3:0] reg_addr_t;

  typedef enum logic [3:0] {
    op_nop = 4'd0,
    op_add = 4'd1,
    op_sub = 4'd2,
    op_mul = 4'd3,
    op_neg = 4'd4,
    op_abs = 4'd5,
    op_mov = 4'd6
  } opcode_t;

  // APB byte addresses
  localparam logic [7:0] ADDR_INSTR    = 8'h00;  // write only
  localparam logic [7:0] ADDR_STATUS   = 8'h04;  // read only
  localparam logic [7:0] ADDR_REG_BASE = 8'h40;  // r at base + 4*r

endpackage

// File: verilog/fp_sign_unit.sv
// ----------------------------------------------------------------------
// sign unit, one stage
// negate, absolute value and move by editing bit 31 only
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module fp_sign_unit
  import fp_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        sign_issue,
  input  opcode_t     issue_op,
  input  reg_addr_t   issue_dest,
  input  logic [31:0] opa,
  output logic        sign_done,
  output reg_addr_t   sign_dest,
  output logic [31:0] sign_result
);

  logic new_sign;

  always_comb begin
    case (issue_op)
      op_neg:  new_sign = ~opa[31];
      op_abs:  new_sign = 1'b0;
      default: new_sign = opa[31];  // mov
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_done <= 1'b0;
    end else begin
      sign_done <= sign_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (sign_issue) begin
      sign_dest   <= issue_dest;
      sign_result <= {new_sign, opa[30:0]};
    end
  end

endmodule

// File: verilog/reg_file.sv
// ----------------------------------------------------------------------
// coprocessor register file, 16 x 32
// three unit writebacks and a host write port, two operand reads and
// one host read, all reads combinational, writebacks bypass to operands
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module reg_file
  import fp_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        add_done,
  input  logic        mul_done,
  input  logic        sign_done,
  input  reg_addr_t   add_dest,
  input  reg_addr_t   mul_dest,
  input  reg_addr_t   sign_dest,
  input  logic [31:0] add_result,
  input  logic [31:0] mul_result,
  input  logic [31:0] sign_result,
  input  logic        host_wr,
  input  reg_addr_t   host_addr,
  input  logic [31:0] host_data,
  input  reg_addr_t   src1,
  input  reg_addr_t   src2,
  output logic [31:0] opa,
  output logic [31:0] opb,
  input  reg_addr_t   host_rd_addr,
  output logic [31:0] host_rd_data
);

  logic [NUM_REGS-1:0][31:0] regs;

  // scoreboard keeps the write addresses disjoint
  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '0;
    end else begin
      if (host_wr) regs[host_addr] <= host_data;
      if (add_done) regs[add_dest] <= add_result;
      if (mul_done) regs[mul_dest] <= mul_result;
      if (sign_done) regs[sign_dest] <= sign_result;
    end
  end

  // scheduler may issue in the writeback cycle, so forward the result
  always_comb begin
    opa = regs[src1];
    if (add_done && (add_dest == src1)) opa = add_result;
    if (mul_done && (mul_dest == src1)) opa = mul_result;
    if (sign_done && (sign_dest == src1)) opa = sign_result;
  end

  always_comb begin
    opb = regs[src2];
    if (add_done && (add_dest == src2)) opb = add_result;
    if (mul_done && (mul_dest == src2)) opb = mul_result;
    if (sign_done && (sign_dest == src2)) opb = sign_result;
  end

  assign host_rd_data = regs[host_rd_addr];

endmodule

// File: verilog/scheduler.sv
// ----------------------------------------------------------------------
// instruction scheduler
// circular instruction queue, register busy scoreboard and in-order
// issue of the queue head to the add, multiply and sign units
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module scheduler
  import fp_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  logic [INSTR_W-1:0]  instr,
  output logic                queue_full,
  output logic [4:0]          queue_count,
  output logic [NUM_REGS-1:0] busy_mask,
  output logic                add_issue,
  output logic                mul_issue,
  output logic                sign_issue,
  output opcode_t             issue_op,
  output reg_addr_t           issue_dest,
  output reg_addr_t           src1,
  output reg_addr_t           src2,
  input  logic                add_done,
  input  logic                mul_done,
  input  logic                sign_done,
  input  reg_addr_t           add_dest,
  input  reg_addr_t           mul_dest,
  input  reg_addr_t           sign_dest
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  logic [INSTR_W-1:0]  queue [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr, rd_ptr;
  logic [4:0]          count;
  logic [NUM_REGS-1:0] busy, done_mask, busy_live, busy_next;
  logic [INSTR_W-1:0]  head;
  logic                uses_src2;
  logic                hazard;
  logic                deq;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign head       = queue[rd_ptr];
  assign issue_op   = opcode_t'(head[15:12]);
  assign issue_dest = head[11:8];
  assign src1       = head[7:4];
  assign src2       = head[3:0];

  // writebacks this cycle already count as free
  always_comb begin
    done_mask = '0;
    if (add_done) done_mask[add_dest] = 1'b1;
    if (mul_done) done_mask[mul_dest] = 1'b1;
    if (sign_done) done_mask[sign_dest] = 1'b1;
  end

  assign busy_live = busy & ~done_mask;
  assign uses_src2 = (issue_op == op_add) || (issue_op == op_sub) || (issue_op == op_mul);
  assign hazard    = busy_live[src1] | busy_live[issue_dest] | (uses_src2 & busy_live[src2]);

  // nop and stray codes leave the queue without a unit strobe
  assign deq        = (count != 5'd0) && ((issue_op == op_nop) || !hazard);
  assign add_issue  = deq && ((issue_op == op_add) || (issue_op == op_sub));
  assign mul_issue  = deq && (issue_op == op_mul);
  assign sign_issue = deq && ((issue_op == op_neg) || (issue_op == op_abs) ||
                              (issue_op == op_mov));

  always_comb begin
    busy_next = busy_live;
    if (add_issue | mul_issue | sign_issue) busy_next[issue_dest] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (instr_valid) queue[wr_ptr] <= instr;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 5'd0;
      busy   <= '0;
    end else begin
      if (instr_valid) wr_ptr <= next_ptr(wr_ptr);
      if (deq) rd_ptr <= next_ptr(rd_ptr);
      count <= count + {4'b0, instr_valid} - {4'b0, deq};
      busy  <= busy_next;
    end
  end

  assign queue_full  = (count == 5'(FIFO_DEPTH));
  assign queue_count = count;
  assign busy_mask   = busy;

endmodule
